// ==== hdl/uart_frame_pkg.sv ====
`default_nettype none

package uart_frame_pkg;

    // Payload byte width.
    localparam int DATA_W = 8;

    // Index width of one data bit within the byte.
    localparam int BIT_IDX_W = $clog2(DATA_W);

    // data_bit_num_i codes. Code n selects n + 5 data bits.
    localparam logic [1:0] DLEN_5 = 2'd0;
    localparam logic [1:0] DLEN_6 = 2'd1;
    localparam logic [1:0] DLEN_7 = 2'd2;
    localparam logic [1:0] DLEN_8 = 2'd3;

endpackage

`default_nettype wire

// ==== hdl/uart_buf_pkg.sv ====
`default_nettype none

package uart_buf_pkg;

    localparam int FIFO_DEPTH = 8;
    localparam int PTR_W      = 3;

    // Occupancy count at which the FIFO reports full.
    localparam logic [PTR_W:0] FIFO_FULL_CNT = (PTR_W + 1)'(FIFO_DEPTH);

    // Clock cycles per serial bit.
    localparam int CLK_PER_BIT = 6;
    localparam int BAUD_CNT_W  = $clog2(CLK_PER_BIT);
    localparam logic [BAUD_CNT_W-1:0] BAUD_LAST = BAUD_CNT_W'(CLK_PER_BIT - 1);

endpackage

`default_nettype wire

// ==== hdl/host_write_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_write_port (
    input  wire                               clk,
    input  wire                               reset_n,
    input  wire                               write_data_i,
    input  wire  [uart_frame_pkg::DATA_W-1:0] data_i,
    output logic                              push_o,
    output logic [uart_frame_pkg::DATA_W-1:0] push_data_o
);

    logic write_d;      // Previous strobe sample.
    logic strobe_fall;

    assign strobe_fall = write_d & ~write_data_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            write_d <= 1'b0;
            push_o  <= 1'b0;
        end else begin
            write_d <= write_data_i;
            push_o  <= strobe_fall;  // One cycle wide.
        end
    end

    // Byte goes out together with the push.
    always_ff @(posedge clk) begin
        if (strobe_fall) begin
            push_data_o <= data_i;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tx_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_fifo (
    input  wire                               clk,
    input  wire                               reset_n,
    input  wire                               push_i,
    input  wire  [uart_frame_pkg::DATA_W-1:0] push_data_i,
    input  wire                               flush_i,
    input  wire                               byte_ack_i,
    output logic                              byte_req_o,
    output logic [uart_frame_pkg::DATA_W-1:0] byte_data_o,
    output logic                              empty_o,
    output logic                              full_o
);
    import uart_frame_pkg::*;
    import uart_buf_pkg::*;

    logic [DATA_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;
    logic              do_push;
    logic              do_pop;

    assign empty_o     = (count == '0);
    assign full_o      = (count == FIFO_FULL_CNT);
    assign do_push     = push_i & ~full_o & ~flush_i;  // Full FIFO drops it.
    assign do_pop      = byte_req_o & byte_ack_i & ~flush_i;
    assign byte_data_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            byte_req_o <= 1'b0;
        end else if (flush_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            byte_req_o <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Request side of the four-phase handshake.
            if (do_pop) begin
                byte_req_o <= 1'b0;
            end else if (!byte_ack_i && !empty_o) begin
                byte_req_o <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/baud_tick_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module baud_tick_gen (
    input  wire  clk,
    input  wire  reset_n,
    output logic bit_tick_o
);
    import uart_buf_pkg::*;

    logic [BAUD_CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cnt        <= '0;
            bit_tick_o <= 1'b0;
        end else if (cnt == BAUD_LAST) begin
            cnt        <= '0;
            bit_tick_o <= 1'b1;  // One tick per bit period.
        end else begin
            cnt        <= cnt + 1'b1;
            bit_tick_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uart_frame_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_frame_tx (
    input  wire                              clk,
    input  wire                              reset_n,
    input  wire                              bit_tick_i,
    input  wire                              byte_req_i,
    input  wire [uart_frame_pkg::DATA_W-1:0] byte_data_i,
    input  wire                              tx_en_i,
    input  wire                              hf_en_i,
    input  wire                              cts_ni,
    input  wire                              parity_en_i,
    input  wire                              parity_type_i,
    input  wire                              stop_bit_num_i,
    input  wire [1:0]                        data_bit_num_i,
    output logic                             byte_ack_o,
    output logic                             tx_o,
    output logic                             trans_fi_o
);
    import uart_frame_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_PARITY,
        S_STOP
    } state_t;

    state_t               state;
    logic                 cts_meta;
    logic                 cts_sync;
    logic                 can_ack;
    logic                 take;
    logic [DATA_W-1:0]    shreg;
    logic [BIT_IDX_W-1:0] bit_cnt;
    logic [BIT_IDX_W-1:0] last_bit;
    logic [1:0]           cfg_dlen;
    logic                 cfg_par_en;
    logic                 cfg_par_odd;
    logic                 cfg_two_stop;
    logic                 par_acc;
    logic [1:0]           stop_cnt;
    logic [1:0]           stop_last;

    // CTS synchronizer. Starts out as not clear to send.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cts_meta <= 1'b1;
            cts_sync <= 1'b1;
        end else begin
            cts_meta <= cts_ni;
            cts_sync <= cts_meta;
        end
    end

    assign can_ack   = tx_en_i & ~(hf_en_i & cts_sync);
    assign take      = (state == S_IDLE) & byte_req_i & ~byte_ack_o & can_ack;
    assign stop_last = cfg_two_stop ? 2'd2 : 2'd1;

    always_comb begin
        case (cfg_dlen)
            DLEN_5: last_bit = BIT_IDX_W'(4);
            DLEN_6: last_bit = BIT_IDX_W'(5);
            DLEN_7: last_bit = BIT_IDX_W'(6);
            DLEN_8: last_bit = BIT_IDX_W'(DATA_W - 1);
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state        <= S_IDLE;
            byte_ack_o   <= 1'b0;
            tx_o         <= 1'b1;
            trans_fi_o   <= 1'b0;
            bit_cnt      <= '0;
            par_acc      <= 1'b0;
            stop_cnt     <= '0;
            cfg_dlen     <= DLEN_8;
            cfg_par_en   <= 1'b0;
            cfg_par_odd  <= 1'b0;
            cfg_two_stop <= 1'b0;
        end else begin
            trans_fi_o <= 1'b0;
            if (take) begin
                byte_ack_o <= 1'b1;
            end else if (!byte_req_i) begin
                byte_ack_o <= 1'b0;  // Phase four.
            end
            case (state)
                S_IDLE: begin
                    if (take) begin
                        cfg_dlen     <= data_bit_num_i;
                        cfg_par_en   <= parity_en_i;
                        cfg_par_odd  <= parity_type_i;
                        cfg_two_stop <= stop_bit_num_i;
                        state        <= S_START;
                    end
                end
                S_START: begin
                    if (bit_tick_i) begin
                        tx_o     <= 1'b0;
                        bit_cnt  <= '0;
                        par_acc  <= 1'b0;
                        stop_cnt <= '0;
                        state    <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (bit_tick_i) begin
                        tx_o    <= shreg[0];  // LSB first.
                        par_acc <= par_acc ^ shreg[0];
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == last_bit) begin
                            state <= cfg_par_en ? S_PARITY : S_STOP;
                        end
                    end
                end
                S_PARITY: begin
                    if (bit_tick_i) begin
                        tx_o  <= par_acc ^ cfg_par_odd;
                        state <= S_STOP;
                    end
                end
                S_STOP: begin
                    // Last tick here closes the final stop bit.
                    if (bit_tick_i) begin
                        tx_o <= 1'b1;
                        if (stop_cnt == stop_last) begin
                            trans_fi_o <= 1'b1;
                            state      <= S_IDLE;
                        end else begin
                            stop_cnt <= stop_cnt + 1'b1;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            shreg <= byte_data_i;
        end else if (state == S_DATA && bit_tick_i) begin
            shreg <= shreg >> 1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uart_tx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx_top (
    input  wire                              clk,
    input  wire                              reset_n,
    input  wire                              write_data_i,
    input  wire [uart_frame_pkg::DATA_W-1:0] data_i,
    input  wire                              fifo_tx_reset_i,
    input  wire                              tx_en_i,
    input  wire                              hf_en_i,
    input  wire                              cts_ni,
    input  wire                              parity_en_i,
    input  wire                              parity_type_i,
    input  wire                              stop_bit_num_i,
    input  wire [1:0]                        data_bit_num_i,
    output wire                              tx_o,
    output wire                              fifo_tx_empty_o,
    output wire                              fifo_tx_full_o,
    output wire                              trans_fi_o
);
    import uart_frame_pkg::*;

    logic              push;
    logic [DATA_W-1:0] push_data;
    logic              byte_req;
    logic              byte_ack;
    logic [DATA_W-1:0] byte_data;
    logic              bit_tick;

    host_write_port u_write_port (
        .clk          (clk),
        .reset_n      (reset_n),
        .write_data_i (write_data_i),
        .data_i       (data_i),
        .push_o       (push),
        .push_data_o  (push_data)
    );

    tx_fifo u_fifo (
        .clk         (clk),
        .reset_n     (reset_n),
        .push_i      (push),
        .push_data_i (push_data),
        .flush_i     (fifo_tx_reset_i),
        .byte_ack_i  (byte_ack),
        .byte_req_o  (byte_req),
        .byte_data_o (byte_data),
        .empty_o     (fifo_tx_empty_o),
        .full_o      (fifo_tx_full_o)
    );

    baud_tick_gen u_baud (
        .clk        (clk),
        .reset_n    (reset_n),
        .bit_tick_o (bit_tick)
    );

    uart_frame_tx u_frame_tx (
        .clk            (clk),
        .reset_n        (reset_n),
        .bit_tick_i     (bit_tick),
        .byte_req_i     (byte_req),
        .byte_data_i    (byte_data),
        .tx_en_i        (tx_en_i),
        .hf_en_i        (hf_en_i),
        .cts_ni         (cts_ni),
        .parity_en_i    (parity_en_i),
        .parity_type_i  (parity_type_i),
        .stop_bit_num_i (stop_bit_num_i),
        .data_bit_num_i (data_bit_num_i),
        .byte_ack_o     (byte_ack),
        .tx_o           (tx_o),
        .trans_fi_o     (trans_fi_o)
    );

endmodule

`default_nettype wire

// ==== sim/uart_tx_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx_sva (
    input wire       clk,
    input wire       reset_n,
    input wire       byte_req_i,
    input wire       byte_ack_i,
    input wire       flush_i,
    input wire       tx_i,
    input wire [2:0] frame_state_i
);

    // A flush on the ack edge may drop the request early.
    ack_needs_req: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(byte_ack_i) |-> byte_req_i || $past(flush_i))
        else $error("byte_ack rose without byte_req");

    req_held: assert property (@(posedge clk) disable iff (!reset_n)
        byte_req_i && !byte_ack_i && !flush_i |=> byte_req_i)
        else $error("byte_req dropped before byte_ack");

    // State code 0 is idle.
    line_idle: assert property (@(posedge clk) disable iff (!reset_n)
        frame_state_i == 3'd0 |-> tx_i)
        else $error("tx_o low while the transmitter is idle");

endmodule

`default_nettype wire

// ==== sim/tb_uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_uart_tx;
    import uart_frame_pkg::*;
    import uart_buf_pkg::*;

    localparam int FRAME_CYC   = 12 * CLK_PER_BIT;  // Longest frame.
    localparam int QUIET_CYC   = 3 * FRAME_CYC;
    localparam int START_LIMIT = 2 * FRAME_CYC;

    logic              clk;
    logic              reset_n;
    logic              write_data_i;
    logic [DATA_W-1:0] data_i;
    logic              fifo_tx_reset_i;
    logic              tx_en_i;
    logic              hf_en_i;
    logic              cts_ni;
    logic              parity_en_i;
    logic              parity_type_i;
    logic              stop_bit_num_i;
    logic [1:0]        data_bit_num_i;
    wire               tx_o;
    wire               fifo_tx_empty_o;
    wire               fifo_tx_full_o;
    wire               trans_fi_o;

    logic [31:0]       rng = 32'h2df846e8;
    logic [DATA_W-1:0] model [$];   // Bytes expected on the line in order of arrival.
    int errors      = 0;
    int frames_seen = 0;
    int fin_seen    = 0;
    int tests_run   = 0;
    int tests_ok    = 0;
    int test_err0   = 0;

    uart_tx_top u_dut (.*);

    bind uart_tx_top uart_tx_sva u_sva (
        .clk           (clk),
        .reset_n       (reset_n),
        .byte_req_i    (byte_req),
        .byte_ack_i    (byte_ack),
        .flush_i       (fifo_tx_reset_i),
        .tx_i          (tx_o),
        .frame_state_i (u_frame_tx.state)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(negedge clk) begin
        if (reset_n && trans_fi_o) begin
            fin_seen++;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic flag_mismatch(input string msg);
        $display("FAILED t=%0t: %s", $time, msg);
        errors++;
    endtask

    task automatic flag_timeout(input string msg);
        $display("timeout at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_err0) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_err0);
        end
        test_err0 = errors;
    endtask

    task automatic random_cfg();
        logic [31:0] r;
        r = next_rand();
        @(negedge clk);
        data_bit_num_i = r[1:0];
        parity_en_i    = r[2];
        parity_type_i  = r[3];
        stop_bit_num_i = r[4];
    endtask

    // Strobe high then low; the push lands two cycles later.
    task automatic write_byte(input logic [DATA_W-1:0] d);
        @(negedge clk);
        write_data_i = 1'b1;
        data_i       = d;
        @(negedge clk);
        write_data_i = 1'b0;
        repeat (2) @(negedge clk);
        if (model.size() < FIFO_DEPTH) begin
            model.push_back(d);
        end
    endtask

    // Decodes one frame from tx_o and checks it against the model head.
    task automatic check_frame();
        int k;
        int nbits;
        logic prev;
        logic seen;
        logic [DATA_W-1:0] got;
        logic [DATA_W-1:0] exp_byte;
        logic [DATA_W-1:0] mask;
        prev = tx_o;
        seen = 1'b0;
        for (k = 0; k < START_LIMIT && !seen; k++) begin
            @(negedge clk);
            seen = prev && !tx_o;
            prev = tx_o;
        end
        if (!seen) begin
            flag_timeout("no start bit appeared on tx_o");
            return;
        end
        repeat (CLK_PER_BIT / 2 - 1) @(negedge clk);  // Middle of the start bit.
        if (tx_o !== 1'b0) flag_mismatch("start bit not held low");
        nbits = 5 + int'(data_bit_num_i);
        mask  = DATA_W'((1 << nbits) - 1);
        got   = '0;
        for (k = 0; k < nbits; k++) begin
            repeat (CLK_PER_BIT) @(negedge clk);
            got[k] = tx_o;
        end
        if (model.size() == 0) begin
            flag_mismatch("frame arrived with no byte queued");
            exp_byte = '0;
        end else begin
            exp_byte = model.pop_front();
        end
        if (got !== (exp_byte & mask)) begin
            flag_mismatch($sformatf("data %h, expected %h", got, exp_byte & mask));
        end
        if (parity_en_i) begin
            repeat (CLK_PER_BIT) @(negedge clk);
            if (tx_o !== (^(exp_byte & mask) ^ parity_type_i)) flag_mismatch("bad parity bit");
        end
        for (k = 0; k <= int'(stop_bit_num_i); k++) begin
            repeat (CLK_PER_BIT) @(negedge clk);
            if (tx_o !== 1'b1) flag_mismatch($sformatf("stop bit %0d low", k));
        end
        frames_seen++;
    endtask

    task automatic expect_quiet(input string why);
        int k;
        int lows;
        lows = 0;
        for (k = 0; k < QUIET_CYC; k++) begin
            @(negedge clk);
            if (tx_o !== 1'b1) lows++;
        end
        if (lows != 0) flag_mismatch({"frame started ", why});
    endtask

    task automatic wait_frames_done();
        int k;
        for (k = 0; k < FRAME_CYC && fin_seen < frames_seen; k++) begin
            @(negedge clk);
        end
        if (fin_seen < frames_seen) flag_timeout("trans_fi_o never marked the frame end");
    endtask

    initial begin
        int b;
        int n;
        int k;
        reset_n         = 1'b0;
        write_data_i    = 1'b0;
        data_i          = '0;
        fifo_tx_reset_i = 1'b0;
        tx_en_i         = 1'b0;
        hf_en_i         = 1'b0;
        cts_ni          = 1'b0;
        parity_en_i     = 1'b0;
        parity_type_i   = 1'b0;
        stop_bit_num_i  = 1'b0;
        data_bit_num_i  = DLEN_8;
        repeat (10) @(negedge clk);
        reset_n = 1'b1;

        @(negedge clk);
        if (tx_o !== 1'b1 || fifo_tx_empty_o !== 1'b1 || fifo_tx_full_o !== 1'b0) begin
            flag_mismatch("outputs not idle after reset");
        end
        finish_test("idle");

        for (b = 0; b < 6; b++) begin
            random_cfg();
            n = 1 + int'(next_rand() % FIFO_DEPTH);
            for (k = 0; k < n; k++) write_byte(DATA_W'(next_rand()));
            tx_en_i = 1'b1;
            for (k = 0; k < n; k++) check_frame();
            wait_frames_done();
            tx_en_i = 1'b0;
        end
        finish_test("frame_contents");

        random_cfg();
        for (k = 0; k <= FIFO_DEPTH; k++) write_byte(DATA_W'(next_rand()));  // Last one dropped.
        if (fifo_tx_full_o !== 1'b1) flag_mismatch("full flag not set");
        tx_en_i = 1'b1;
        for (k = 0; k < FIFO_DEPTH; k++) check_frame();
        expect_quiet("after the FIFO drained");
        tx_en_i = 1'b0;
        finish_test("full_fifo");

        random_cfg();
        hf_en_i = 1'b1;
        cts_ni  = 1'b1;
        tx_en_i = 1'b1;
        for (k = 0; k < 3; k++) write_byte(DATA_W'(next_rand()));
        expect_quiet("while CTS blocked the line");
        cts_ni = 1'b0;
        for (k = 0; k < 3; k++) check_frame();
        wait_frames_done();
        tx_en_i = 1'b0;
        hf_en_i = 1'b0;
        cts_ni  = 1'b1;  // Ignored with flow control off.
        for (k = 0; k < 3; k++) write_byte(DATA_W'(next_rand()));
        tx_en_i = 1'b1;
        for (k = 0; k < 3; k++) check_frame();
        wait_frames_done();
        tx_en_i = 1'b0;
        cts_ni  = 1'b0;
        finish_test("flow_control");

        for (k = 0; k < 4; k++) write_byte(DATA_W'(next_rand()));
        if (fifo_tx_empty_o !== 1'b0) flag_mismatch("FIFO empty with bytes queued");
        fifo_tx_reset_i = 1'b1;
        @(negedge clk);
        fifo_tx_reset_i = 1'b0;
        @(negedge clk);
        if (fifo_tx_empty_o !== 1'b1) flag_mismatch("FIFO not empty after flush");
        model.delete();
        tx_en_i = 1'b1;
        expect_quiet("after a flush");
        tx_en_i = 1'b0;
        finish_test("flush");

        if (fin_seen != frames_seen) begin
            flag_mismatch($sformatf("%0d frame-end pulses for %0d frames", fin_seen, frames_seen));
        end
        finish_test("frame_end_pulse");

        $display("%0d of %0d tests ok, %0d errors", tests_ok, tests_run, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
hdl/uart_frame_pkg.sv
hdl/uart_buf_pkg.sv
hdl/host_write_port.sv
hdl/tx_fifo.sv
hdl/baud_tick_gen.sv
hdl/uart_frame_tx.sv
hdl/uart_tx_top.sv
sim/uart_tx_sva.sv
sim/tb_uart_tx.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the UART transmitter testbench with Verilator.
set -e -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module tb_uart_tx -o sim_uart_tx
./obj_dir/sim_uart_tx | tee sim.log

if grep -q "tests failed" sim.log; then
    exit 1
fi
exit 0
